// ==== bpu_fe.f ====
common/bpu_pkg.sv
common/fetch_pkg.sv
bpu/bpu_table.sv
bpu/bpu_ras.sv
bpu/bpu_train.sv
bpu/bpu.sv
sim/bpu_checker.sv
sim/tb_bpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bpu
FLIST     ?= bpu_fe.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= *** TEST PASSED ***

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$($(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_bpu.sv ====
module tb_bpu;
    timeunit 1ns;
    timeprecision 1ps;
    import bpu_pkg::*;
    import fetch_pkg::*;

    localparam int            NUM_TESTS = 6;
    localparam correct_info_t NO_REC    = '0; // idle correction port

    logic          clk = 1'b0;
    logic          rst_n;
    logic          flush;
    logic [31:0]   redir_addr;
    correct_info_t corr_0;
    correct_info_t corr_1;
    logic          bundle_valid;
    logic          bundle_ready;
    fetch_bundle_t bundle;

    // reference model state
    btb_entry_t          btb_m  [2][BTB_DEPTH];
    logic [HIST_LEN-1:0] hist_m [2][BTB_DEPTH];
    logic [1:0]          cnt_m  [2][PHT_DEPTH];
    logic [31:0]         ras_m  [$];   // newest at the back
    logic [31:0]         pc_m;         // expected fetch pc this cycle
    logic [31:0]         lcg_state;

    always #50 clk = ~clk; // 100 ns period

    bpu u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (flush),
        .redir_addr_i     (redir_addr),
        .correct_info_0_i (corr_0),
        .correct_info_1_i (corr_1),
        .bundle_valid_o   (bundle_valid),
        .bundle_ready_i   (bundle_ready),
        .bundle_o         (bundle)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_bundle(input fetch_bundle_t exp, input fetch_bundle_t act,
                                input string what);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch at %0d ns: %s expected %h got %h",
                                $time, what, exp, act));
        end
    endtask

    task automatic check_pc(input logic [31:0] exp, input logic [31:0] act, input string what);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch at %0d ns: %s expected %h got %h",
                                $time, what, exp, act));
        end
    endtask

    task automatic check_flag(input logic exp, input logic act, input string what);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch at %0d ns: %s expected %b got %b",
                                $time, what, exp, act));
        end
    endtask

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] rand_block();
        logic [31:0] w;
        w = rand_word();
        return {w[31:3], 3'b000};
    endfunction

    function automatic logic [31:0] rand_target();
        logic [31:0] w;
        w = rand_word();
        return {w[31:2], 2'b00};
    endfunction

    // index folds pc[17:9] onto pc[11:3], tag is the 8 bits from 12
    function automatic logic [BTB_IDX_LEN-1:0] index_of(input logic [31:0] pc);
        return pc[17:9] ^ pc[11:3];
    endfunction

    function automatic logic [TAG_LEN-1:0] tag_of(input logic [31:0] pc);
        return pc[19:12];
    endfunction

    function automatic logic [1:0] counter_step(input logic [1:0] c, input logic taken);
        if (taken) begin
            return (c == 2'b11) ? c : c + 2'd1;
        end
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    function automatic fetch_bundle_t expected_bundle(input logic [31:0] pc);
        fetch_bundle_t       b;
        btb_entry_t          e;
        logic [HIST_LEN-1:0] h;
        logic [1:0]          c;
        logic                tm;
        logic [31:0]         ras_top;
        b       = '0;
        b.pc    = pc;
        ras_top = (ras_m.size() > 0) ? ras_m[$] : 32'd0; // empty stack reads zero
        for (int i = 0; i < 2; i++) begin
            e  = btb_m[i][index_of(pc)];
            h  = hist_m[i][index_of(pc)];
            c  = cnt_m[i][{h, pc[10:3]}];
            tm = (e.tag == tag_of(pc));
            b.pred[i].target_pc   = (e.br_type == BR_RET) ? ras_top : e.target_pc;
            b.pred[i].is_branch   = e.is_branch;
            b.pred[i].br_type     = e.br_type;
            b.pred[i].taken       = e.is_branch & tm & ((e.br_type != BR_NORMAL) | c[1]);
            b.pred[i].scnt        = c;
            b.pred[i].history     = h;
            b.pred[i].need_update = ~tm;
        end
        b.pred[0].next_pc = b.pred[0].taken ? b.pred[0].target_pc : {pc[31:3], 3'b100};
        b.pred[1].next_pc = b.pred[1].taken ? b.pred[1].target_pc
                                            : {pc[31:3] + 29'd1, 3'b000};
        b.mask = {~b.pred[0].taken | pc[2], ~pc[2]};
        return b;
    endfunction

    function automatic logic [31:0] next_fetch_pc(input logic [31:0] pc);
        fetch_bundle_t b;
        b = expected_bundle(pc);
        if (b.pred[0].taken && !pc[2]) begin
            return b.pred[0].target_pc;
        end else if (b.pred[1].taken) begin
            return b.pred[1].target_pc;
        end
        return {pc[31:3] + 29'd1, 3'b000};
    endfunction

    function automatic void model_train(input correct_info_t r);
        logic [BTB_IDX_LEN-1:0] idx;
        logic                   bank;
        idx  = index_of(r.pc);
        bank = r.pc[2];
        if (r.type_miss || r.target_miss) begin
            btb_m[bank][idx].tag       = tag_of(r.pc);
            btb_m[bank][idx].target_pc = r.target_pc;
            btb_m[bank][idx].br_type   = r.br_type;
            btb_m[bank][idx].is_branch = r.is_branch;
        end
        hist_m[bank][idx] = r.type_miss ? {{(HIST_LEN-1){1'b0}}, r.taken}
                                        : {r.history[HIST_LEN-2:0], r.taken};
        cnt_m[bank][{r.history, r.pc[10:3]}] = counter_step(r.scnt, r.taken);
        if (r.br_type == BR_CALL) begin
            if (ras_m.size() == RAS_DEPTH) begin
                void'(ras_m.pop_front()); // oldest lost
            end
            ras_m.push_back(r.pc + 32'd4);
        end else if (r.br_type == BR_RET && ras_m.size() > 0) begin
            void'(ras_m.pop_back());
        end
    endfunction

    // record as the back end would send it, with history and counter from lookup
    function automatic correct_info_t make_rec(input logic [31:0] pc, input logic [31:0] target,
                                               input br_type_t kind, input logic taken,
                                               input logic type_miss, input logic target_miss);
        correct_info_t       r;
        logic [HIST_LEN-1:0] h;
        h             = hist_m[pc[2]][index_of(pc)];
        r             = '0;
        r.update      = 1'b1;
        r.pc          = pc;
        r.target_pc   = target;
        r.br_type     = kind;
        r.is_branch   = 1'b1;
        r.taken       = taken;
        r.type_miss   = type_miss;
        r.target_miss = target_miss;
        r.history     = h;
        r.scnt        = cnt_m[pc[2]][{h, pc[10:3]}];
        return r;
    endfunction

    // one cycle, inputs on the rising edge, outputs checked at the falling edge
    task automatic run_cycle(input logic ready, input logic do_flush, input logic [31:0] redir,
                             input correct_info_t r0, input correct_info_t r1);
        @(posedge clk);
        bundle_ready <= ready;
        flush        <= do_flush;
        redir_addr   <= redir;
        corr_0       <= r0;
        corr_1       <= r1;
        @(negedge clk);
        check_flag(1'b1, bundle_valid, "bundle valid");
        check_pc(pc_m, bundle.pc, "fetch pc");
        check_bundle(expected_bundle(pc_m), bundle, "bundle");
        if (do_flush) begin
            pc_m = redir; // flush wins over accept
        end else if (ready) begin
            pc_m = next_fetch_pc(pc_m);
        end
        if (r0.update) begin
            model_train(r0);
        end else if (r1.update) begin
            model_train(r1);
        end
    endtask

    task automatic fetch_one();
        run_cycle(1'b1, 1'b0, 32'd0, NO_REC, NO_REC);
    endtask

    task automatic stall_one();
        run_cycle(1'b0, 1'b0, 32'd0, NO_REC, NO_REC);
    endtask

    task automatic flush_to(input logic [31:0] addr);
        run_cycle(1'b0, 1'b1, addr, NO_REC, NO_REC);
    endtask

    task automatic train(input correct_info_t r0, input correct_info_t r1);
        run_cycle(1'b0, 1'b0, 32'd0, r0, r1);
    endtask

    task automatic reset_and_fetch();
        int n;
        n = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        while (bundle_valid !== 1'b1) begin
            if (n == 8) begin
                abort_run("bundle valid did not rise after reset");
            end
            @(negedge clk);
            n++;
        end
        check_pc(BPU_INIT_PC, bundle.pc, "first fetch pc");
        check_flag(1'b1, bundle.mask[0], "first mask bit 0");
        check_flag(1'b1, bundle.mask[1], "first mask bit 1");
        repeat (6) fetch_one();
        check_pc(BPU_INIT_PC + 32'd40, bundle.pc, "sequential pc");
    endtask

    task automatic hold_and_flush();
        logic [31:0] held;
        logic [31:0] addr;
        held = pc_m;
        repeat (5) stall_one();
        check_pc(held, bundle.pc, "pc under back-pressure");
        addr = rand_block() | 32'd4; // enter at slot 1
        flush_to(addr);
        stall_one();
        check_pc(addr, bundle.pc, "pc after flush");
        check_flag(1'b0, bundle.mask[0], "mask bit 0 after odd flush");
        check_flag(1'b1, bundle.mask[1], "mask bit 1 after odd flush");
    endtask

    task automatic jump_training();
        logic [31:0] blk;
        logic [31:0] tgt;
        blk = rand_block();
        tgt = rand_target();
        train(make_rec(blk | 32'd4, tgt, BR_JUMP, 1'b1, 1'b0, 1'b1), NO_REC);
        flush_to(blk);
        fetch_one();
        check_flag(1'b1, bundle.pred[1].taken, "slot 1 jump taken");
        stall_one();
        check_pc(tgt, bundle.pc, "pc after slot 1 jump");
        tgt = rand_target();
        train(make_rec(blk, tgt, BR_JUMP, 1'b1, 1'b0, 1'b1), NO_REC);
        flush_to(blk);
        stall_one();
        check_flag(1'b1, bundle.pred[0].taken, "slot 0 jump taken");
        check_flag(1'b0, bundle.mask[1], "slot 1 dropped behind taken slot 0");
    endtask

    task automatic counter_training();
        logic [31:0]         br;
        logic [31:0]         tgt;
        logic [HIST_LEN-1:0] h;
        logic                taken;
        br  = rand_block();
        tgt = rand_target();
        train(make_rec(br, tgt, BR_NORMAL, 1'b1, 1'b1, 1'b0), NO_REC); // installs the entry
        flush_to(br);
        for (int k = 0; k < 20; k++) begin
            // eight taken, then rounds of one not taken and five taken
            // so the history returns to all ones and the same counter is read
            taken = (k < 8) || ((k - 8) % 6 != 0);
            train(make_rec(br, tgt, BR_NORMAL, taken, 1'b0, 1'b0), NO_REC);
            stall_one();
            h = hist_m[0][index_of(br)];
            check_flag(cnt_m[0][{h, br[10:3]}][1], bundle.pred[0].taken, "counter direction");
            if (k == 7) begin
                check_flag(1'b1, bundle.pred[0].taken, "saturated taken");
            end
            if (k == 13) begin
                check_flag(1'b1, bundle.pred[0].taken, "weakly taken after one step back");
            end
        end
        check_flag(1'b0, bundle.pred[0].taken, "not taken after two steps back");
    endtask

    task automatic return_stack();
        logic [31:0] ret_pc;
        logic [31:0] call_1;
        logic [31:0] call_2;
        ret_pc = rand_block();
        call_1 = rand_target();
        call_2 = rand_target();
        // install first so its pop meets an empty stack
        train(make_rec(ret_pc, 32'd0, BR_RET, 1'b1, 1'b1, 1'b0), NO_REC);
        train(make_rec(call_1, rand_target(), BR_CALL, 1'b1, 1'b0, 1'b0), NO_REC);
        train(make_rec(call_2, rand_target(), BR_CALL, 1'b1, 1'b0, 1'b0), NO_REC);
        flush_to(ret_pc);
        stall_one();
        check_pc(call_2 + 32'd4, bundle.pred[0].target_pc, "return to last call");
        train(make_rec(ret_pc, 32'd0, BR_RET, 1'b1, 1'b0, 1'b0), NO_REC);
        stall_one();
        check_pc(call_1 + 32'd4, bundle.pred[0].target_pc, "return after one pop");
    endtask

    task automatic record_select();
        logic [31:0]   pa;
        logic [31:0]   pb;
        logic [31:0]   ta;
        logic [31:0]   tb;
        correct_info_t ra;
        correct_info_t rb;
        pa = rand_block() | 32'd4;
        pb = pa + 32'h1000; // new tag and index
        ta = rand_target();
        tb = rand_target();
        ra = make_rec(pa, ta, BR_JUMP, 1'b1, 1'b0, 1'b1);
        rb = make_rec(pb, tb, BR_JUMP, 1'b1, 1'b0, 1'b1);
        train(ra, rb);
        flush_to(pa);
        stall_one();
        check_flag(1'b1, bundle.pred[1].taken, "record 0 trained");
        check_pc(ta, bundle.pred[1].target_pc, "record 0 target");
        flush_to(pb);
        stall_one();
        check_flag(1'b0, bundle.pred[1].taken, "record 1 ignored");
        ra.update = 1'b0;
        rb = make_rec(pb, tb, BR_JUMP, 1'b1, 1'b0, 1'b1);
        train(ra, rb);
        stall_one();
        check_flag(1'b1, bundle.pred[1].taken, "record 1 trained");
        check_pc(tb, bundle.pred[1].target_pc, "record 1 target");
    endtask

    // bound assertions count their failures
    always @(negedge clk) begin
        if (u_dut.u_checker.fail_count != 0) begin
            abort_run("a bound checker assertion failed");
        end
    end

    initial begin
        repeat (200 * NUM_TESTS) @(posedge clk);
        abort_run("timeout: tests did not finish in time");
    end

    initial begin
        rst_n        = 1'b0;
        flush        = 1'b0;
        redir_addr   = 32'd0;
        corr_0       = NO_REC;
        corr_1       = NO_REC;
        bundle_ready = 1'b0;
        lcg_state    = 32'd87765;
        pc_m         = BPU_INIT_PC;
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < BTB_DEPTH; i++) begin
                btb_m[b][i]  = '0;
                hist_m[b][i] = '0;
            end
            for (int i = 0; i < PHT_DEPTH; i++) begin
                cnt_m[b][i] = 2'b00;
            end
        end
        reset_and_fetch();
        hold_and_flush();
        jump_training();
        counter_training();
        return_stack();
        record_select();
        if (u_dut.u_checker.fail_count != 0) begin
            abort_run("checker assertion failed during the run");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// ==== sim/bpu_checker.sv ====
module bpu_checker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush_i,
    input  logic                     bundle_ready_i,
    input  logic                     bundle_valid_i,
    input  fetch_pkg::fetch_bundle_t bundle_i,
    input  fetch_pkg::correct_info_t correct_info_0_i,
    input  fetch_pkg::correct_info_t correct_info_1_i,
    input  logic [31:0]              pc_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0; // read by the testbench

    // sync reset clears valid on the edge
    a_valid_in_reset : assert property (@(posedge clk) !rst_n |=> !bundle_valid_i)
        else begin
            $error("bundle valid high while in reset");
            fail_count++;
        end

    // tables only move on a correction, pc only on flush or accept
    a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n)
        (bundle_valid_i && !bundle_ready_i && !flush_i
         && !correct_info_0_i.update && !correct_info_1_i.update) |=> $stable(bundle_i))
        else begin
            $error("bundle changed under back-pressure without a correction");
            fail_count++;
        end

    a_pc_aligned : assert property (@(posedge clk) disable iff (!rst_n) pc_i[1:0] == 2'b00)
        else begin
            $error("fetch pc not word aligned");
            fail_count++;
        end

endmodule

bind bpu bpu_checker u_checker (
    .clk              (clk),
    .rst_n            (rst_n),
    .flush_i          (flush_i),
    .bundle_ready_i   (bundle_ready_i),
    .bundle_valid_i   (bundle_valid_o),
    .bundle_i         (bundle_o),
    .correct_info_0_i (correct_info_0_i),
    .correct_info_1_i (correct_info_1_i),
    .pc_i             (pc)
);

// ==== bpu/bpu.sv ====
module bpu (
    input  logic                     clk,
    input  logic                     rst_n,

    // redirect from the back end
    input  logic                     flush_i,
    input  logic [31:0]              redir_addr_i,

    // training records
    input  fetch_pkg::correct_info_t correct_info_0_i,
    input  fetch_pkg::correct_info_t correct_info_1_i,

    // fetch bundle sender
    output logic                     bundle_valid_o,
    input  logic                     bundle_ready_i,
    output fetch_pkg::fetch_bundle_t bundle_o
);
    import bpu_pkg::*;
    import fetch_pkg::*;

    logic [31:0] pc;
    logic [31:0] pc_next;   // chosen next fetch pc
    logic [31:0] pc_add_8;  // next 8-byte block
    logic        valid_q;
    logic        fire;      // bundle taken this cycle

    // table read side
    logic [BTB_IDX_LEN-1:0] btb_raddr;
    btb_entry_t             btb_rdata [FETCH_WIDTH];
    bht_entry_t             bht_rdata [FETCH_WIDTH];
    logic [PHT_IDX_LEN-1:0] pht_raddr [FETCH_WIDTH];
    pht_entry_t             pht_rdata [FETCH_WIDTH];
    logic [31:0]            ras_top;

    // training side
    logic                   btb_we;
    logic [BTB_IDX_LEN-1:0] btb_waddr;
    btb_entry_t             btb_wdata;
    logic                   bht_we;
    logic [BTB_IDX_LEN-1:0] bht_waddr;
    bht_entry_t             bht_wdata;
    logic                   pht_we;
    logic [PHT_IDX_LEN-1:0] pht_waddr;
    pht_entry_t             pht_wdata;
    logic                   wbank;
    logic                   ras_push;
    logic                   ras_pop;
    logic [31:0]            ras_push_addr;

    // per slot decision
    logic [FETCH_WIDTH-1:0] tag_match;
    logic [FETCH_WIDTH-1:0] hit;
    logic [FETCH_WIDTH-1:0] branch;
    logic [31:0]            target_pc [FETCH_WIDTH];
    logic [31:0]            slot_next [FETCH_WIDTH];
    logic [FETCH_WIDTH-1:0] mask;

    // valid comes up one cycle after reset release
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
        end
    end

    assign bundle_valid_o = valid_q;
    assign fire           = bundle_valid_o & bundle_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= BPU_INIT_PC;
        end else if (flush_i) begin
            pc <= redir_addr_i; // flush beats acceptance
        end else if (fire) begin
            pc <= pc_next;
        end
        // otherwise held under back-pressure
    end

    assign btb_raddr = btb_hash(pc); // btb and bht index both banks alike

    bpu_train u_train (
        .correct_info_0_i (correct_info_0_i),
        .correct_info_1_i (correct_info_1_i),
        .btb_we_o         (btb_we),
        .btb_waddr_o      (btb_waddr),
        .btb_wdata_o      (btb_wdata),
        .bht_we_o         (bht_we),
        .bht_waddr_o      (bht_waddr),
        .bht_wdata_o      (bht_wdata),
        .pht_we_o         (pht_we),
        .pht_waddr_o      (pht_waddr),
        .pht_wdata_o      (pht_wdata),
        .wbank_o          (wbank),
        .ras_push_o       (ras_push),
        .ras_pop_o        (ras_pop),
        .ras_push_addr_o  (ras_push_addr)
    );

    bpu_table #(
        .DEPTH   (BTB_DEPTH),
        .entry_t (btb_entry_t)
    ) u_btb (
        .clk       (clk),
        .rst_n     (rst_n),
        .raddr_0_i (btb_raddr),
        .raddr_1_i (btb_raddr),
        .rdata_0_o (btb_rdata[0]),
        .rdata_1_o (btb_rdata[1]),
        .we_i      (btb_we),
        .wbank_i   (wbank),
        .waddr_i   (btb_waddr),
        .wdata_i   (btb_wdata)
    );

    bpu_table #(
        .DEPTH   (BTB_DEPTH),
        .entry_t (bht_entry_t)
    ) u_bht (
        .clk       (clk),
        .rst_n     (rst_n),
        .raddr_0_i (btb_raddr),
        .raddr_1_i (btb_raddr),
        .rdata_0_o (bht_rdata[0]),
        .rdata_1_o (bht_rdata[1]),
        .we_i      (bht_we),
        .wbank_i   (wbank),
        .waddr_i   (bht_waddr),
        .wdata_i   (bht_wdata)
    );

    // pht read address differs per slot since history does
    bpu_table #(
        .DEPTH   (PHT_DEPTH),
        .entry_t (pht_entry_t)
    ) u_pht (
        .clk       (clk),
        .rst_n     (rst_n),
        .raddr_0_i (pht_raddr[0]),
        .raddr_1_i (pht_raddr[1]),
        .rdata_0_o (pht_rdata[0]),
        .rdata_1_o (pht_rdata[1]),
        .we_i      (pht_we),
        .wbank_i   (wbank),
        .waddr_i   (pht_waddr),
        .wdata_i   (pht_wdata)
    );

    bpu_ras u_ras (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (ras_push),
        .pop_i       (ras_pop),
        .push_addr_i (ras_push_addr),
        .top_o       (ras_top)
    );

    assign pc_add_8 = {pc[31:3] + 29'd1, 3'b000};

    for (genvar i = 0; i < FETCH_WIDTH; i++) begin : g_slot
        assign pht_raddr[i] = {bht_rdata[i].history, pc[PHT_PC_LEN+2:3]};
        assign tag_match[i] = (btb_rdata[i].tag == get_tag(pc));
        assign hit[i]       = btb_rdata[i].is_branch & tag_match[i];
        // unconditional kinds always go, conditional asks the counter
        assign branch[i]    = hit[i] & ((btb_rdata[i].br_type != BR_NORMAL)
                                        | pht_rdata[i].scnt[1]);
        assign target_pc[i] = (btb_rdata[i].br_type == BR_RET) ? ras_top
                                                               : btb_rdata[i].target_pc;
    end

    // fall-through of each slot
    assign slot_next[0] = branch[0] ? target_pc[0] : {pc[31:3], 3'b100};
    assign slot_next[1] = branch[1] ? target_pc[1] : pc_add_8;

    always_comb begin
        pc_next = pc_add_8;
        if (branch[0] && !pc[2]) begin
            pc_next = target_pc[0]; // slot 0 only counts when live
        end else if (branch[1]) begin
            pc_next = target_pc[1];
        end
    end

    // slot 1 dead after a taken slot 0, slot 0 dead on odd entry
    assign mask = {~branch[0] | pc[2], ~pc[2]};

    always_comb begin
        bundle_o.pc   = pc;
        bundle_o.mask = mask;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            bundle_o.pred[i].target_pc   = target_pc[i];
            bundle_o.pred[i].next_pc     = slot_next[i];
            bundle_o.pred[i].is_branch   = btb_rdata[i].is_branch;
            bundle_o.pred[i].br_type     = btb_rdata[i].br_type;
            bundle_o.pred[i].taken       = branch[i];
            bundle_o.pred[i].scnt        = pht_rdata[i].scnt;
            bundle_o.pred[i].history     = bht_rdata[i].history;
            bundle_o.pred[i].need_update = ~tag_match[i]; // no entry for this pc
        end
    end

endmodule

// ==== bpu/bpu_train.sv ====
module bpu_train (
    input  fetch_pkg::correct_info_t             correct_info_0_i,
    input  fetch_pkg::correct_info_t             correct_info_1_i,

    // btb write
    output logic                                 btb_we_o,
    output logic [bpu_pkg::BTB_IDX_LEN-1:0]      btb_waddr_o,
    output bpu_pkg::btb_entry_t                  btb_wdata_o,

    // bht write, same index as btb
    output logic                                 bht_we_o,
    output logic [bpu_pkg::BTB_IDX_LEN-1:0]      bht_waddr_o,
    output bpu_pkg::bht_entry_t                  bht_wdata_o,

    // pht write
    output logic                                 pht_we_o,
    output logic [bpu_pkg::PHT_IDX_LEN-1:0]      pht_waddr_o,
    output bpu_pkg::pht_entry_t                  pht_wdata_o,

    output logic                                 wbank_o, // shared by all three tables

    // ras
    output logic                                 ras_push_o,
    output logic                                 ras_pop_o,
    output logic [31:0]                          ras_push_addr_o
);
    import bpu_pkg::*;
    import fetch_pkg::*;

    correct_info_t          applied; // the one record trained this cycle
    logic [BTB_IDX_LEN-1:0] idx;

    // first record with update set wins
    assign applied = correct_info_0_i.update ? correct_info_0_i : correct_info_1_i;

    assign idx     = btb_hash(applied.pc);
    assign wbank_o = applied.pc[2]; // slot of the branch in its block

    // btb only rewritten when the entry was wrong or missing
    assign btb_we_o    = applied.update & (applied.type_miss | applied.target_miss);
    assign btb_waddr_o = idx;

    always_comb begin
        btb_wdata_o.tag       = get_tag(applied.pc);
        btb_wdata_o.target_pc = applied.target_pc;
        btb_wdata_o.br_type   = applied.br_type;
        btb_wdata_o.is_branch = applied.is_branch;
    end

    assign bht_we_o    = applied.update;
    assign bht_waddr_o = idx;

    always_comb begin
        if (applied.type_miss) begin
            // fresh entry, old history belonged to someone else
            bht_wdata_o.history = {{(HIST_LEN-1){1'b0}}, applied.taken};
        end else begin
            bht_wdata_o.history = {applied.history[HIST_LEN-2:0], applied.taken};
        end
    end

    // pht trained at the index it was read from
    assign pht_we_o         = applied.update;
    assign pht_waddr_o      = {applied.history, applied.pc[PHT_PC_LEN+2:3]};
    assign pht_wdata_o.scnt = next_scnt(applied.scnt, applied.taken);

    // stack kept by resolved calls and returns only
    assign ras_push_o      = applied.update & (applied.br_type == BR_CALL);
    assign ras_pop_o       = applied.update & (applied.br_type == BR_RET);
    assign ras_push_addr_o = applied.pc + 32'd4; // link address

endmodule

// ==== bpu/bpu_ras.sv ====
module bpu_ras (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push_i,      // call seen
    input  logic        pop_i,       // return seen
    input  logic [31:0] push_addr_i, // call pc + 4
    output logic [31:0] top_o
);
    import bpu_pkg::*;

    logic [31:0]            stack [RAS_DEPTH];
    logic [RAS_PTR_LEN-1:0] top_ptr;  // points at newest entry
    logic [RAS_PTR_LEN-1:0] push_ptr; // slot above the top, wraps
    logic [RAS_PTR_LEN:0]   count;    // live entries, saturates at depth
    logic                   empty;
    logic                   full;
    logic                   do_pop;   // pop that actually takes effect

    assign push_ptr = top_ptr + 1'b1;
    assign empty    = (count == '0);
    assign full     = (count == (RAS_PTR_LEN+1)'(RAS_DEPTH));
    assign do_pop   = pop_i & ~empty; // empty pop dropped

    // nothing valid to return to when empty
    assign top_o = empty ? 32'd0 : stack[top_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (push_i && do_pop) begin
            stack[top_ptr] <= push_addr_i; // replace top in place
        end else if (push_i) begin
            stack[push_ptr] <= push_addr_i; // overwrites oldest once full
        end
    end

    // pointer and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_ptr <= '1; // first push lands in entry 0
            count   <= '0;
        end else if (push_i && !do_pop) begin
            top_ptr <= push_ptr;
            if (!full) begin
                count <= count + 1'b1;
            end
        end else if (do_pop && !push_i) begin
            top_ptr <= top_ptr - 1'b1;
            count   <= count - 1'b1;
        end
        // push with pop keeps both
    end

endmodule

// ==== bpu/bpu_table.sv ====
module bpu_table #(
    parameter int  DEPTH   = 512,
    parameter type entry_t = logic [1:0]
) (
    input  logic                     clk,
    input  logic                     rst_n,

    // one async read port per bank
    input  logic [$clog2(DEPTH)-1:0] raddr_0_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_1_i,
    output entry_t                   rdata_0_o,
    output entry_t                   rdata_1_o,

    // single write port, bank picked by wbank_i
    input  logic                     we_i,
    input  logic                     wbank_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  entry_t                   wdata_i
);

    entry_t bank_0 [DEPTH]; // slot 0, pc[2] == 0
    entry_t bank_1 [DEPTH]; // slot 1, pc[2] == 1

    // distributed ram style read, no latency
    assign rdata_0_o = bank_0[raddr_0_i];
    assign rdata_1_o = bank_1[raddr_1_i];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // every entry back to zero so no stale hits
            for (int i = 0; i < DEPTH; i++) begin
                bank_0[i] <= '0;
                bank_1[i] <= '0;
            end
        end else if (we_i) begin
            if (wbank_i) begin
                bank_1[waddr_i] <= wdata_i;
            end else begin
                bank_0[waddr_i] <= wdata_i;
            end
        end
    end

endmodule

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    localparam int FETCH_WIDTH = 2; // slots per fetch bundle

    // what the predictor says about one slot, carried down the pipe
    // so the back end can send it back with the correction
    typedef struct packed {
        logic [31:0]                  target_pc;   // btb target or ras top
        logic [31:0]                  next_pc;     // pc after this slot
        logic                         is_branch;
        bpu_pkg::br_type_t            br_type;
        logic                         taken;       // predicted direction
        logic [1:0]                   scnt;        // counter as read
        logic [bpu_pkg::HIST_LEN-1:0] history;     // history as read
        logic                         need_update; // tag missed
    } predict_info_t;

    typedef struct packed {
        logic [31:0]                        pc;   // 8-byte aligned block, bit 2 may be set
        logic [FETCH_WIDTH-1:0]             mask; // bit i means slot i is live
        predict_info_t [FETCH_WIDTH-1:0]    pred;
    } fetch_bundle_t;

    // training record from the back end
    typedef struct packed {
        logic                         update;      // record carries a correction
        logic [31:0]                  pc;          // pc of the branch itself
        logic [31:0]                  target_pc;   // resolved target
        bpu_pkg::br_type_t            br_type;
        logic                         is_branch;
        logic                         taken;       // resolved direction
        logic                         type_miss;   // btb had wrong or no type
        logic                         target_miss; // btb had wrong target
        logic [1:0]                   scnt;        // counter used at predict
        logic [bpu_pkg::HIST_LEN-1:0] history;     // history used at predict
    } correct_info_t;

endpackage

// ==== common/bpu_pkg.sv ====
package bpu_pkg;

    localparam logic [31:0] BPU_INIT_PC = 32'h1c00_0000; // fetch pc out of reset

    // btb and bht share the same index
    localparam int BTB_IDX_LEN = 9;
    localparam int BTB_DEPTH   = 1 << BTB_IDX_LEN;
    localparam int TAG_LEN     = 8;  // pc bits from 12 upward

    localparam int HIST_LEN    = 5;  // local history per slot

    // pht index is {history, pc[10:3]}
    localparam int PHT_PC_LEN  = 8;
    localparam int PHT_IDX_LEN = HIST_LEN + PHT_PC_LEN;
    localparam int PHT_DEPTH   = 1 << PHT_IDX_LEN;

    localparam int RAS_DEPTH   = 8;
    localparam int RAS_PTR_LEN = 3;

    // BR_NORMAL is the only kind that asks the pht
    typedef enum logic [1:0] {
        BR_NORMAL = 2'd0, // conditional
        BR_JUMP   = 2'd1, // b, jirl not used as return
        BR_CALL   = 2'd2, // bl
        BR_RET    = 2'd3  // jirl r0, r1
    } br_type_t;

    typedef struct packed {
        logic [TAG_LEN-1:0] tag;
        logic [31:0]        target_pc;
        br_type_t           br_type;
        logic               is_branch; // doubles as entry valid
    } btb_entry_t;

    typedef struct packed {
        logic [HIST_LEN-1:0] history; // newest outcome in bit 0
    } bht_entry_t;

    typedef struct packed {
        logic [1:0] scnt; // bit 1 set means predict taken
    } pht_entry_t;

    // folds upper pc bits into the index, tied to BTB_IDX_LEN of 9
    function automatic logic [BTB_IDX_LEN-1:0] btb_hash(input logic [31:0] pc);
        return pc[17:9] ^ pc[11:3];
    endfunction

    function automatic logic [TAG_LEN-1:0] get_tag(input logic [31:0] pc);
        return pc[TAG_LEN+11:12];
    endfunction

    // 2-bit saturating step
    function automatic logic [1:0] next_scnt(input logic [1:0] scnt, input logic taken);
        logic [1:0] res;
        res = scnt;
        if (taken && scnt != 2'b11) begin
            res = scnt + 2'd1;
        end else if (!taken && scnt != 2'b00) begin
            res = scnt - 2'd1;
        end
        return res;
    endfunction

endpackage
